// File: Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - design/rv_decode_pkg.sv
      - design/decode_input_hold.sv
      - design/inst_decoder.sv
      - design/reg_file.sv
      - design/hazard_detect.sv
      - design/decode_output_reg.sv
      - design/decode_stage.sv
  - target: test
    files:
      - testbench/decode_stage_assert.sv
      - testbench/tb_decode_stage.sv

// File: decode_stage.f
design/rv_decode_pkg.sv
design/decode_input_hold.sv
design/inst_decoder.sv
design/reg_file.sv
design/hazard_detect.sv
design/decode_output_reg.sv
design/decode_stage.sv
testbench/decode_stage_assert.sv
testbench/tb_decode_stage.sv

// File: design/decode_input_hold.sv
// instruction and PC selection between incoming, saved and flushed pair, with save registers
module decode_input_hold import rv_decode_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  inst_t inst_in,
    input  word_t pc_in,
    input  logic  mem_stall,
    input  logic  branch_flush,
    output inst_t inst_cur,
    output word_t pc_cur
);

    inst_t save_inst;
    word_t save_pc;

    always_comb begin
        if (branch_flush) begin
            inst_cur = INST_NOP;
            pc_cur   = PC_NOP;
        end else if (mem_stall) begin
            inst_cur = save_inst; // replay held instruction
            pc_cur   = save_pc;
        end else begin
            inst_cur = inst_in;
            pc_cur   = pc_in;
        end
    end

    // on a flush the current pair is already the NOP
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            save_inst <= INST_NOP;
            save_pc   <= PC_NOP;
        end else begin
            save_inst <= inst_cur;
            save_pc   <= pc_cur;
        end
    end

endmodule

// File: design/decode_output_reg.sv
// operand multiplexers and the decode pipeline register with bubble insertion
module decode_output_reg import rv_decode_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hazard_stall,
    input  word_t     pc_cur,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     imm_i,
    input  word_t     imm_s,
    input  word_t     imm_b,
    input  word_t     imm_j,
    input  word_t     imm_u,
    input  op1_sel_e  op1_sel,
    input  op2_sel_e  op2_sel,
    input  alu_fun_e  alu_fun,
    input  mem_fun_e  mem_fun,
    input  logic      rf_wen,
    input  wb_sel_e   wb_sel,
    input  reg_addr_t rd_addr,
    input  logic      jmp_flg,
    output word_t     pc_out,
    output word_t     op1_data,
    output word_t     op2_data,
    output word_t     rs2_out,
    output word_t     imm_b_out,
    output alu_fun_e  alu_fun_out,
    output mem_fun_e  mem_fun_out,
    output logic      rf_wen_out,
    output wb_sel_e   wb_sel_out,
    output reg_addr_t wb_addr_out,
    output logic      jmp_flg_out
);

    word_t op1_mux;
    word_t op2_mux;

    always_comb begin
        case (op1_sel)
            OP1_RS1: op1_mux = rs1_data;
            OP1_PC:  op1_mux = pc_cur;
            default: op1_mux = '0;
        endcase
        case (op2_sel)
            OP2_RS2: op2_mux = rs2_data;
            OP2_IMI: op2_mux = imm_i;
            OP2_IMS: op2_mux = imm_s;
            OP2_IMJ: op2_mux = imm_j;
            OP2_IMU: op2_mux = imm_u;
            default: op2_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || hazard_stall) begin // bubble
            pc_out      <= BUBBLE_WORD;
            op1_data    <= BUBBLE_WORD;
            op2_data    <= BUBBLE_WORD;
            rs2_out     <= BUBBLE_WORD;
            imm_b_out   <= BUBBLE_WORD;
            alu_fun_out <= ALU_ADD;
            mem_fun_out <= MEM_NONE;
            rf_wen_out  <= 1'b0;
            wb_sel_out  <= WB_NONE;
            wb_addr_out <= '0;
            jmp_flg_out <= 1'b0;
        end else begin
            pc_out      <= pc_cur;
            op1_data    <= op1_mux;
            op2_data    <= op2_mux;
            rs2_out     <= rs2_data; // store data
            imm_b_out   <= imm_b;
            alu_fun_out <= alu_fun;
            mem_fun_out <= mem_fun;
            rf_wen_out  <= rf_wen;
            wb_sel_out  <= wb_sel;
            wb_addr_out <= rd_addr;
            jmp_flg_out <= jmp_flg;
        end
    end

endmodule

// File: design/decode_stage.sv
// RV32I decode stage top with input hold, decoder, register file, hazard check and output register
module decode_stage import rv_decode_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  inst_t     inst_in,
    input  word_t     pc_in,
    input  logic      mem_stall,
    input  logic      branch_flush,
    input  logic      exe_rf_wen,
    input  reg_addr_t exe_wb_addr,
    input  logic      mem_rf_wen,
    input  reg_addr_t mem_wb_addr,
    input  logic      wb_rf_wen,
    input  reg_addr_t wb_wb_addr,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output logic      hazard_stall,
    output word_t     pc_out,
    output word_t     op1_data,
    output word_t     op2_data,
    output word_t     rs2_out,
    output word_t     imm_b_out,
    output alu_fun_e  alu_fun_out,
    output mem_fun_e  mem_fun_out,
    output logic      rf_wen_out,
    output wb_sel_e   wb_sel_out,
    output reg_addr_t wb_addr_out,
    output logic      jmp_flg_out
);

    inst_t     inst_cur;
    word_t     pc_cur;
    alu_fun_e  alu_fun;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    mem_fun_e  mem_fun;
    logic      rf_wen;
    wb_sel_e   wb_sel;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_j;
    word_t     imm_u;
    logic      jmp_flg;
    word_t     rs1_data;
    word_t     rs2_data;

    decode_input_hold u_hold (
        .clk, .rst_n, .inst_in, .pc_in, .mem_stall, .branch_flush,
        .inst_cur, .pc_cur
    );

    inst_decoder u_dec (
        .inst (inst_cur),
        .alu_fun, .op1_sel, .op2_sel, .mem_fun, .rf_wen, .wb_sel,
        .rs1_addr, .rs2_addr, .rd_addr,
        .imm_i, .imm_s, .imm_b, .imm_j, .imm_u, .jmp_flg
    );

    reg_file u_rf (
        .clk, .rst_n, .rs1_addr, .rs2_addr,
        .wb_en, .wb_addr, .wb_data,
        .rs1_data, .rs2_data
    );

    hazard_detect u_haz (
        .rs1_addr, .rs2_addr, .op1_sel, .op2_sel,
        .exe_rf_wen, .exe_wb_addr, .mem_rf_wen, .mem_wb_addr,
        .wb_rf_wen, .wb_wb_addr,
        .hazard_stall
    );

    decode_output_reg u_out (
        .clk, .rst_n, .hazard_stall, .pc_cur, .rs1_data, .rs2_data,
        .imm_i, .imm_s, .imm_b, .imm_j, .imm_u,
        .op1_sel, .op2_sel, .alu_fun, .mem_fun, .rf_wen, .wb_sel, .rd_addr, .jmp_flg,
        .pc_out, .op1_data, .op2_data, .rs2_out, .imm_b_out,
        .alu_fun_out, .mem_fun_out, .rf_wen_out, .wb_sel_out, .wb_addr_out, .jmp_flg_out
    );

endmodule

// File: design/hazard_detect.sv
// data hazard check of the used source registers against the execute, memory and writeback writers
module hazard_detect import rv_decode_pkg::*; (
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  op1_sel_e  op1_sel,
    input  op2_sel_e  op2_sel,
    input  logic      exe_rf_wen,
    input  reg_addr_t exe_wb_addr,
    input  logic      mem_rf_wen,
    input  reg_addr_t mem_wb_addr,
    input  logic      wb_rf_wen,
    input  reg_addr_t wb_wb_addr,
    output logic      hazard_stall
);

    logic use_rs1;
    logic use_rs2;
    logic hit_exe;
    logic hit_mem;
    logic hit_wb;

    // x0 never creates a dependency
    assign use_rs1 = (op1_sel == OP1_RS1) && (rs1_addr != '0);
    assign use_rs2 = (op2_sel == OP2_RS2) && (rs2_addr != '0);

    assign hit_exe = exe_rf_wen &&
                     ((use_rs1 && exe_wb_addr == rs1_addr) ||
                      (use_rs2 && exe_wb_addr == rs2_addr));

    assign hit_mem = mem_rf_wen &&
                     ((use_rs1 && mem_wb_addr == rs1_addr) ||
                      (use_rs2 && mem_wb_addr == rs2_addr));

    assign hit_wb  = wb_rf_wen &&
                     ((use_rs1 && wb_wb_addr == rs1_addr) ||
                      (use_rs2 && wb_wb_addr == rs2_addr));

    assign hazard_stall = hit_exe || hit_mem || hit_wb;

endmodule

// File: design/inst_decoder.sv
// RV32I decode table, immediate generation and register field extraction
module inst_decoder import rv_decode_pkg::*; (
    input  inst_t     inst,
    output alu_fun_e  alu_fun,
    output op1_sel_e  op1_sel,
    output op2_sel_e  op2_sel,
    output mem_fun_e  mem_fun,
    output logic      rf_wen,
    output wb_sel_e   wb_sel,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output word_t     imm_i,
    output word_t     imm_s,
    output word_t     imm_b,
    output word_t     imm_j,
    output word_t     imm_u,
    output logic      jmp_flg
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_shift;
    logic       valid;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    // shared by register and immediate ALU forms
    function automatic alu_fun_e alu_op(input logic [2:0] f3, input logic alt);
        alu_op = ALU_ADD;
        case (f3)
            F3_ADD_SUB: alu_op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SRL_SRA: alu_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            F3_AND:     alu_op = ALU_AND;
        endcase
    endfunction

    always_comb begin
        valid   = 1'b1;
        alu_fun = ALU_ADD;
        op1_sel = OP1_RS1;
        op2_sel = OP2_NONE;
        mem_fun = MEM_NONE;
        rf_wen  = 1'b0;
        wb_sel  = WB_NONE;
        jmp_flg = 1'b0;
        case (opcode)
            OPC_LOAD: begin
                op2_sel = OP2_IMI;
                rf_wen  = 1'b1;
                case (funct3)
                    F3_LB: begin
                        mem_fun = MEM_LB;
                        wb_sel  = WB_MEMB;
                    end
                    F3_LBU: begin
                        mem_fun = MEM_LBU;
                        wb_sel  = WB_MEMBU;
                    end
                    F3_LH: begin
                        mem_fun = MEM_LH;
                        wb_sel  = WB_MEMH;
                    end
                    F3_LHU: begin
                        mem_fun = MEM_LHU;
                        wb_sel  = WB_MEMHU;
                    end
                    F3_LW: begin
                        mem_fun = MEM_LW;
                        wb_sel  = WB_MEMW;
                    end
                    default: valid = 1'b0;
                endcase
            end
            OPC_STORE: begin
                op2_sel = OP2_IMS;
                case (funct3)
                    F3_SB:   mem_fun = MEM_SB;
                    F3_SH:   mem_fun = MEM_SH;
                    F3_SW:   mem_fun = MEM_SW;
                    default: valid = 1'b0;
                endcase
            end
            OPC_OP: begin
                op2_sel = OP2_RS2;
                rf_wen  = 1'b1;
                wb_sel  = WB_ALU;
                alu_fun = alu_op(funct3, funct7[5]);
                if (funct7 != F7_BASE &&
                    !(funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA))) begin
                    valid = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                op2_sel = OP2_IMI;
                rf_wen  = 1'b1;
                wb_sel  = WB_ALU;
                alu_fun = alu_op(funct3, is_shift && funct7[5]); // addi has no sub form
                if (is_shift && funct7 != F7_BASE &&
                    !(funct7 == F7_ALT && funct3 == F3_SRL_SRA)) begin
                    valid = 1'b0;
                end
            end
            OPC_BRANCH: begin
                op2_sel = OP2_RS2;
                case (funct3)
                    F3_BEQ:  alu_fun = BR_BEQ;
                    F3_BNE:  alu_fun = BR_BNE;
                    F3_BLT:  alu_fun = BR_BLT;
                    F3_BGE:  alu_fun = BR_BGE;
                    F3_BLTU: alu_fun = BR_BLTU;
                    F3_BGEU: alu_fun = BR_BGEU;
                    default: valid = 1'b0;
                endcase
            end
            OPC_JAL: begin
                op1_sel = OP1_PC;
                op2_sel = OP2_IMJ;
                rf_wen  = 1'b1;
                wb_sel  = WB_PC; // link address
                jmp_flg = 1'b1;
            end
            OPC_JALR: begin
                alu_fun = ALU_JALR;
                op2_sel = OP2_IMI;
                rf_wen  = 1'b1;
                wb_sel  = WB_PC;
                jmp_flg = 1'b1;
                valid   = (funct3 == F3_JALR);
            end
            OPC_LUI: begin
                op1_sel = OP1_NONE;
                op2_sel = OP2_IMU;
                rf_wen  = 1'b1;
                wb_sel  = WB_ALU;
            end
            OPC_AUIPC: begin
                op1_sel = OP1_PC;
                op2_sel = OP2_IMU;
                rf_wen  = 1'b1;
                wb_sel  = WB_ALU;
            end
            default: valid = 1'b0;
        endcase

        // unknown encoding falls back to a harmless add
        if (!valid) begin
            alu_fun = ALU_ADD;
            op1_sel = OP1_NONE;
            op2_sel = OP2_NONE;
            mem_fun = MEM_NONE;
            rf_wen  = 1'b0;
            wb_sel  = WB_NONE;
            jmp_flg = 1'b0;
        end
    end

endmodule

// File: design/reg_file.sv
// 32-entry register file, two combinational read ports, one writeback port, x0 reads zero
module reg_file import rv_decode_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [1:31]; // no storage for x0

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // same-cycle write shows up next cycle
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: design/rv_decode_pkg.sv
// word and register types, control encodings, ISA opcodes and funct fields for RV32I decode
package rv_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_JALR,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } alu_fun_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_NONE
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_RS2,
        OP2_IMI,
        OP2_IMS,
        OP2_IMJ,
        OP2_IMU,
        OP2_NONE
    } op2_sel_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_fun_e;

    typedef enum logic [2:0] {
        WB_NONE,
        WB_ALU,
        WB_MEMB,
        WB_MEMBU,
        WB_MEMH,
        WB_MEMHU,
        WB_MEMW,
        WB_PC
    } wb_sel_e;

    localparam inst_t INST_NOP    = 32'h0000_0013; // addi x0, x0, 0
    localparam word_t PC_NOP      = 32'h0000_0000;
    localparam word_t BUBBLE_WORD = 32'hffff_ffff;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // also addi
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

endpackage

// File: testbench/decode_stage_assert.sv
// concurrent assertions on reset, bubble insertion and flush of the decode stage
module decode_stage_assert import rv_decode_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      branch_flush,
    input logic      hazard_stall,
    input word_t     pc_out,
    input word_t     op1_data,
    input word_t     op2_data,
    input word_t     rs2_out,
    input word_t     imm_b_out,
    input alu_fun_e  alu_fun_out,
    input mem_fun_e  mem_fun_out,
    input logic      rf_wen_out,
    input wb_sel_e   wb_sel_out,
    input reg_addr_t wb_addr_out,
    input logic      jmp_flg_out
);

    int n_fail = 0;

    reset_no_write: assert property (@(posedge clk) !rst_n |=> !rf_wen_out)
    else begin
        n_fail++;
        $error("rf_wen_out high right after reset");
    end

    // the edge after a stall loads the bubble
    stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_stall |=> (!rf_wen_out && !jmp_flg_out && mem_fun_out == MEM_NONE &&
                          wb_sel_out == WB_NONE && alu_fun_out == ALU_ADD &&
                          wb_addr_out == '0 && op1_data == BUBBLE_WORD &&
                          op2_data == BUBBLE_WORD && pc_out == BUBBLE_WORD &&
                          rs2_out == BUBBLE_WORD && imm_b_out == BUBBLE_WORD))
    else begin
        n_fail++;
        $error("outputs are not a bubble after hazard_stall");
    end

    flush_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        branch_flush |-> !hazard_stall)
    else begin
        n_fail++;
        $error("hazard_stall raised during branch_flush");
    end

endmodule

bind decode_stage decode_stage_assert u_assert (.*);

// File: testbench/tb_decode_stage.sv
// decode stage testbench with random instructions, reference model, compare tasks and watchdog
module tb_decode_stage import rv_decode_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_OPS    = 2000;
    localparam int SEED       = 5;

    logic      clk;
    logic      rst_n;
    inst_t     inst_in;
    word_t     pc_in;
    logic      mem_stall;
    logic      branch_flush;
    logic      wr_en [3]; // exe, mem, wb writers
    reg_addr_t wr_addr [3];
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      hazard_stall;
    word_t     pc_out;
    word_t     op1_data;
    word_t     op2_data;
    word_t     rs2_out;
    word_t     imm_b_out;
    alu_fun_e  alu_fun_out;
    mem_fun_e  mem_fun_out;
    logic      rf_wen_out;
    wb_sel_e   wb_sel_out;
    reg_addr_t wb_addr_out;
    logic      jmp_flg_out;

    // reference model state
    word_t     m_regs [32];
    inst_t     m_save_inst;
    word_t     m_save_pc;
    alu_fun_e  d_alu;
    op1_sel_e  d_op1;
    op2_sel_e  d_op2;
    mem_fun_e  d_mem;
    logic      d_wen;
    wb_sel_e   d_wbsel;
    logic      d_jmp;

    // expected outputs one cycle ahead
    word_t     e_pc;
    word_t     e_op1;
    word_t     e_op2;
    word_t     e_rs2;
    word_t     e_immb;
    alu_fun_e  e_alu;
    mem_fun_e  e_mem;
    logic      e_wen;
    wb_sel_e   e_wbsel;
    reg_addr_t e_wbaddr;
    logic      e_jmp;
    logic      e_haz;

    int n_checks = 0;
    int n_errors = 0;

    decode_stage u_dut (
        .clk, .rst_n, .inst_in, .pc_in, .mem_stall, .branch_flush,
        .exe_rf_wen  (wr_en[0]),
        .exe_wb_addr (wr_addr[0]),
        .mem_rf_wen  (wr_en[1]),
        .mem_wb_addr (wr_addr[1]),
        .wb_rf_wen   (wr_en[2]),
        .wb_wb_addr  (wr_addr[2]),
        .wb_en, .wb_addr, .wb_data, .hazard_stall,
        .pc_out, .op1_data, .op2_data, .rs2_out, .imm_b_out,
        .alu_fun_out, .mem_fun_out, .rf_wen_out, .wb_sel_out, .wb_addr_out, .jmp_flg_out
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic tally(input string name, input logic bad, input string got, input string exp);
        n_checks++;
        if (bad) begin
            n_errors++;
            $display("CHECK FAILED t=%0t %s got %s expected %s", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        tally(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_alu_fun(input string name, input alu_fun_e got, input alu_fun_e exp);
        tally(name, got !== exp, got.name(), exp.name());
    endtask

    task automatic check_mem_fun(input string name, input mem_fun_e got, input mem_fun_e exp);
        tally(name, got !== exp, got.name(), exp.name());
    endtask

    task automatic check_wb_sel(input string name, input wb_sel_e got, input wb_sel_e exp);
        tally(name, got !== exp, got.name(), exp.name());
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        tally(name, got !== exp, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        tally(name, got !== exp, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic set_ctrl(input alu_fun_e f, input op1_sel_e a, input op2_sel_e b,
                            input mem_fun_e m, input logic w, input wb_sel_e s, input logic j);
        d_alu   = f;
        d_op1   = a;
        d_op2   = b;
        d_mem   = m;
        d_wen   = w;
        d_wbsel = s;
        d_jmp   = j;
    endtask

    // RV32I table keyed on funct7, funct3, opcode
    task automatic decode_ref(input inst_t i);
        casez ({i[31:25], i[14:12], i[6:0]})
            17'b???????_000_0000011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMI, MEM_LB, 1, WB_MEMB, 0);
            17'b???????_001_0000011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMI, MEM_LH, 1, WB_MEMH, 0);
            17'b???????_010_0000011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMI, MEM_LW, 1, WB_MEMW, 0);
            17'b???????_100_0000011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMI, MEM_LBU, 1, WB_MEMBU, 0);
            17'b???????_101_0000011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMI, MEM_LHU, 1, WB_MEMHU, 0);
            17'b???????_000_0100011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMS, MEM_SB, 0, WB_NONE, 0);
            17'b???????_001_0100011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMS, MEM_SH, 0, WB_NONE, 0);
            17'b???????_010_0100011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMS, MEM_SW, 0, WB_NONE, 0);
            17'b0000000_000_0110011: set_ctrl(ALU_ADD, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0100000_000_0110011: set_ctrl(ALU_SUB, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_001_0110011: set_ctrl(ALU_SLL, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_010_0110011: set_ctrl(ALU_SLT, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_011_0110011: set_ctrl(ALU_SLTU, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_100_0110011: set_ctrl(ALU_XOR, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_101_0110011: set_ctrl(ALU_SRL, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0100000_101_0110011: set_ctrl(ALU_SRA, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_110_0110011: set_ctrl(ALU_OR, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_111_0110011: set_ctrl(ALU_AND, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0);
            17'b???????_000_0010011: set_ctrl(ALU_ADD, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_001_0010011: set_ctrl(ALU_SLL, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b???????_010_0010011: set_ctrl(ALU_SLT, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b???????_011_0010011: set_ctrl(ALU_SLTU, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b???????_100_0010011: set_ctrl(ALU_XOR, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b0000000_101_0010011: set_ctrl(ALU_SRL, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b0100000_101_0010011: set_ctrl(ALU_SRA, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b???????_110_0010011: set_ctrl(ALU_OR, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b???????_111_0010011: set_ctrl(ALU_AND, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_ALU, 0);
            17'b???????_000_1100011: set_ctrl(BR_BEQ, OP1_RS1, OP2_RS2, MEM_NONE, 0, WB_NONE, 0);
            17'b???????_001_1100011: set_ctrl(BR_BNE, OP1_RS1, OP2_RS2, MEM_NONE, 0, WB_NONE, 0);
            17'b???????_100_1100011: set_ctrl(BR_BLT, OP1_RS1, OP2_RS2, MEM_NONE, 0, WB_NONE, 0);
            17'b???????_101_1100011: set_ctrl(BR_BGE, OP1_RS1, OP2_RS2, MEM_NONE, 0, WB_NONE, 0);
            17'b???????_110_1100011: set_ctrl(BR_BLTU, OP1_RS1, OP2_RS2, MEM_NONE, 0, WB_NONE, 0);
            17'b???????_111_1100011: set_ctrl(BR_BGEU, OP1_RS1, OP2_RS2, MEM_NONE, 0, WB_NONE, 0);
            17'b???????_???_1101111: set_ctrl(ALU_ADD, OP1_PC, OP2_IMJ, MEM_NONE, 1, WB_PC, 1);
            17'b???????_000_1100111: set_ctrl(ALU_JALR, OP1_RS1, OP2_IMI, MEM_NONE, 1, WB_PC, 1);
            17'b???????_???_0110111: set_ctrl(ALU_ADD, OP1_NONE, OP2_IMU, MEM_NONE, 1, WB_ALU, 0);
            17'b???????_???_0010111: set_ctrl(ALU_ADD, OP1_PC, OP2_IMU, MEM_NONE, 1, WB_ALU, 0);
            default:                 set_ctrl(ALU_ADD, OP1_NONE, OP2_NONE, MEM_NONE, 0, WB_NONE, 0);
        endcase
    endtask

    // retry until the word hits a row of the table
    task automatic pick_inst(output inst_t i);
        logic [6:0] opcs [9];
        opcs = '{OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM, OPC_BRANCH,
                 OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};
        do begin
            i = $urandom;
            i[6:0] = opcs[$urandom_range(8)];
            if (i[6:0] == OPC_OP || (i[6:0] == OPC_OP_IMM && i[13:12] == 2'b01)) begin
                i[31:25] = ($urandom_range(1) == 1) ? F7_ALT : F7_BASE;
            end
            if ($urandom_range(7) == 0) begin
                i[19:15] = '0; // x0 source
            end
            decode_ref(i);
        end while (d_op2 == OP2_NONE);
    endtask

    task automatic set_bubble();
        e_pc     = BUBBLE_WORD;
        e_op1    = BUBBLE_WORD;
        e_op2    = BUBBLE_WORD;
        e_rs2    = BUBBLE_WORD;
        e_immb   = BUBBLE_WORD;
        e_alu    = ALU_ADD;
        e_mem    = MEM_NONE;
        e_wen    = 1'b0;
        e_wbsel  = WB_NONE;
        e_wbaddr = '0;
        e_jmp    = 1'b0;
    endtask

    task automatic drive_inputs();
        if (!e_haz) begin // upstream holds while stalled
            pick_inst(inst_in);
            pc_in = $urandom & 32'hffff_fffc;
        end
        mem_stall    = ($urandom_range(7) == 0);
        branch_flush = ($urandom_range(15) == 0);
        for (int k = 0; k < 3; k++) begin
            wr_en[k] = ($urandom_range(1) == 1);
            case ($urandom_range(7))
                0:       wr_addr[k] = inst_in[19:15];
                1:       wr_addr[k] = inst_in[24:20];
                default: wr_addr[k] = reg_addr_t'($urandom);
            endcase
        end
        wb_en   = ($urandom_range(1) == 1);
        wb_addr = reg_addr_t'($urandom);
        wb_data = $urandom;
    endtask

    task automatic predict();
        inst_t i;
        word_t pc;
        logic  use1;
        logic  use2;
        i  = branch_flush ? INST_NOP : (mem_stall ? m_save_inst : inst_in);
        pc = branch_flush ? PC_NOP : (mem_stall ? m_save_pc : pc_in);
        decode_ref(i);
        use1  = (d_op1 == OP1_RS1) && (i[19:15] != 5'd0);
        use2  = (d_op2 == OP2_RS2) && (i[24:20] != 5'd0);
        e_haz = 1'b0;
        for (int k = 0; k < 3; k++) begin
            if (wr_en[k] && ((use1 && wr_addr[k] == i[19:15]) ||
                             (use2 && wr_addr[k] == i[24:20]))) begin
                e_haz = 1'b1;
            end
        end
        if (e_haz) begin
            set_bubble();
        end else begin
            e_pc = pc;
            e_op1 = (d_op1 == OP1_RS1) ? m_regs[i[19:15]] : ((d_op1 == OP1_PC) ? pc : '0);
            case (d_op2)
                OP2_RS2: e_op2 = m_regs[i[24:20]];
                OP2_IMI: e_op2 = word_t'($signed(i[31:20]));
                OP2_IMS: e_op2 = word_t'($signed({i[31:25], i[11:7]}));
                OP2_IMJ: e_op2 = word_t'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
                OP2_IMU: e_op2 = {i[31:12], 12'h000};
                default: e_op2 = '0;
            endcase
            e_rs2    = m_regs[i[24:20]];
            e_immb   = word_t'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
            e_alu    = d_alu;
            e_mem    = d_mem;
            e_wen    = d_wen;
            e_wbsel  = d_wbsel;
            e_wbaddr = i[11:7];
            e_jmp    = d_jmp;
        end
        m_save_inst = i;
        m_save_pc   = pc;
        if (wb_en && wb_addr != 5'd0) begin
            m_regs[wb_addr] = wb_data; // lands at the coming edge
        end
    endtask

    task automatic check_outputs();
        check_word("pc_out", pc_out, e_pc);
        check_word("op1_data", op1_data, e_op1);
        check_word("op2_data", op2_data, e_op2);
        check_word("rs2_out", rs2_out, e_rs2);
        check_word("imm_b_out", imm_b_out, e_immb);
        check_alu_fun("alu_fun_out", alu_fun_out, e_alu);
        check_mem_fun("mem_fun_out", mem_fun_out, e_mem);
        check_bit("rf_wen_out", rf_wen_out, e_wen);
        check_wb_sel("wb_sel_out", wb_sel_out, e_wbsel);
        check_addr("wb_addr_out", wb_addr_out, e_wbaddr);
        check_bit("jmp_flg_out", jmp_flg_out, e_jmp);
    endtask

    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_in      = INST_NOP;
        pc_in        = PC_NOP;
        mem_stall    = 1'b0;
        branch_flush = 1'b0;
        wb_en        = 1'b0;
        wb_addr      = '0;
        wb_data      = '0;
        for (int k = 0; k < 3; k++) begin
            wr_en[k]   = 1'b0;
            wr_addr[k] = '0;
        end
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        m_save_inst = INST_NOP;
        m_save_pc   = PC_NOP;
        e_haz       = 1'b0;
        set_bubble(); // reset leaves a bubble
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (NUM_OPS) begin
            check_outputs();
            drive_inputs();
            predict();
            #1;
            check_bit("hazard_stall", hazard_stall, e_haz);
            @(negedge clk);
        end
        check_outputs();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, u_dut.u_assert.n_fail);
        if (n_errors == 0 && u_dut.u_assert.n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(NUM_OPS * CLK_PERIOD * 4);
        $display("timeout: the run did not complete all operations in time");
        $display("Something failed");
        $finish;
    end

endmodule
